// ==== hdl/musicBoxPkg.sv ====
// Types and constants shared by the tone path
// Samples are unsigned and 0 is the most negative level
// Sine table holds only the first quarter of the wave
// DAC frames are 4 control bits followed by a 12-bit code

package musicBoxPkg;

	//----------------------------------------------------------------------
	// Data types
	//----------------------------------------------------------------------
	typedef logic [7:0]  sampleT;  // Waveform or mix level
	typedef logic [7:0]  gainT;    // Amplitude ratio where 255 is unity
	typedef logic [15:0] phaseT;   // Accumulator and step per sample
	typedef logic [11:0] dacCodeT; // DAC input code

	//----------------------------------------------------------------------
	// DAC serial frame
	//----------------------------------------------------------------------
	localparam int dacFrameWidth = 16; // Bits per frame on the wire

	// Leading nibble of every frame
	// All zero selects normal write and update on the DAC
	localparam logic [3:0] dacControlBits = 4'b0000;

	//----------------------------------------------------------------------
	// Quarter-wave sine
	//----------------------------------------------------------------------
	// Entry i is round(127.5 + 127.5*sin(2*pi*(i + 0.5)/256))
	// Half-step offset keeps the wave symmetric about 127.5
	// Index 64..127 mirrors the table and 128..255 inverts it (255 - value)
	localparam sampleT sineQuarterTable [64] = '{
		8'd129, 8'd132, 8'd135, 8'd138, 8'd142, 8'd145, 8'd148, 8'd151,
		8'd154, 8'd157, 8'd160, 8'd163, 8'd166, 8'd169, 8'd172, 8'd175,
		8'd178, 8'd181, 8'd183, 8'd186, 8'd189, 8'd192, 8'd194, 8'd197,
		8'd200, 8'd202, 8'd205, 8'd207, 8'd210, 8'd212, 8'd214, 8'd217,
		8'd219, 8'd221, 8'd223, 8'd225, 8'd227, 8'd229, 8'd231, 8'd233,
		8'd234, 8'd236, 8'd238, 8'd239, 8'd241, 8'd242, 8'd243, 8'd245,
		8'd246, 8'd247, 8'd248, 8'd249, 8'd250, 8'd251, 8'd252, 8'd252,
		8'd253, 8'd253, 8'd254, 8'd254, 8'd255, 8'd255, 8'd255, 8'd255
	};

endpackage

// ==== hdl/sampleStrobe.sv ====
// Audio sample-rate enable made from the system clock
// Emits a one-cycle tick every clocksPerSample clocks
// clocksPerSample must be 2 or more

module sampleStrobe #(
	parameter int clocksPerSample = 1562 // 50 MHz / 1562 is about 32 kHz
) (
	input  logic clock_50Mhz,
	input  logic reset,
	output logic sampleTick // High for one clock per sample
);
	localparam int countWidth = $clog2(clocksPerSample);
	localparam logic [countWidth-1:0] lastCount = countWidth'(clocksPerSample - 1);

	logic [countWidth-1:0] cycleCount; // Clocks since the last tick

	//----------------------------------------------------------------------
	// Divider
	//----------------------------------------------------------------------
	// Same counting idea as a clock divider but the result is an enable
	// First tick lands clocksPerSample clocks after reset drops
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			cycleCount <= '0;
			sampleTick <= 1'b0;
		end else if (cycleCount == lastCount) begin
			cycleCount <= '0; // Wrap
			sampleTick <= 1'b1;
		end else begin
			cycleCount <= cycleCount + 1'b1;
			sampleTick <= 1'b0;
		end
	end

endmodule

// ==== hdl/toneOscillator.sv ====
// Phase accumulator with sine and triangle lookup
// Phase is zero after reset so sample k belongs to phase k*toneStep
// toneStep may change between ticks and takes effect on the next one
// Top 8 phase bits pick the waveform point and the low bits are dropped

module toneOscillator import musicBoxPkg::*; (
	input  logic   clock_50Mhz,
	input  logic   reset,
	input  logic   sampleTick,     // One pulse per audio sample
	input  phaseT  toneStep,       // Phase advance per sample
	output sampleT sineSample,
	output sampleT triangleSample,
	output logic   toneValid       // Both waves valid in this cycle
);
	//----------------------------------------------------------------------
	// Phase accumulator
	//----------------------------------------------------------------------
	phaseT phase;         // Current tone phase
	logic  lookupPending; // Phase stepped last cycle

	// Step lands the cycle after the tick
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			phase <= '0;
			lookupPending <= 1'b0;
		end else begin
			lookupPending <= sampleTick;
			if (sampleTick) begin
				phase <= phase + toneStep; // Wraps at 16 bits
			end
		end
	end

	//----------------------------------------------------------------------
	// Waveform lookup
	//----------------------------------------------------------------------
	logic [7:0] waveIndex;    // Point within one period
	logic [5:0] quarterIndex; // Folded table address
	sampleT     quarterValue;
	sampleT     sineValue;
	sampleT     triangleValue;

	assign waveIndex = phase[15:8];

	// Quarters 1 and 3 read the table backwards
	assign quarterIndex = waveIndex[6] ? ~waveIndex[5:0] : waveIndex[5:0];
	assign quarterValue = sineQuarterTable[quarterIndex];

	// Second half of the period is the first half inverted about 127.5
	assign sineValue = waveIndex[7] ? (8'd255 - quarterValue) : quarterValue;

	// Ramp up as 2n for n below 128
	// Ramp down as 2*(255 - n) and 255 - n is just the inverted low 7 bits
	assign triangleValue = waveIndex[7] ? {~waveIndex[6:0], 1'b0}
		: {waveIndex[6:0], 1'b0};

	//----------------------------------------------------------------------
	// Output register
	//----------------------------------------------------------------------
	// Valid follows the tick by 2 clocks
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			toneValid <= 1'b0;
		end else begin
			toneValid <= lookupPending;
		end
	end

	// Both waves load together so they always share a phase
	always_ff @(posedge clock_50Mhz) begin
		if (lookupPending) begin
			sineSample <= sineValue;
			triangleSample <= triangleValue; // Held until the next sample
		end
	end

endmodule

// ==== hdl/amplitudeMixer.sv ====
// Stage 1 weights each wave by its gain and adds them with saturation
// Stage 2 applies the master volume and widens to a 12-bit DAC code
// Gain scaling rounds as (a*g + 127)/255 so gain 255 passes a unchanged
// Each stage has its own valid so two samples can be in flight

module amplitudeMixer import musicBoxPkg::*; (
	input  logic    clock_50Mhz,
	input  logic    reset,
	input  sampleT  sineSample,
	input  sampleT  triangleSample,
	input  logic    toneValid,
	input  gainT    sineGain,
	input  gainT    triangleGain,
	input  gainT    volume,       // Master level after the sum
	output dacCodeT mixCode,
	output logic    mixValid      // Two clocks after toneValid
);
	// Rounded a*g/255
	// Largest sum is 65025 + 127 and still fits 16 bits
	function automatic sampleT scale(input sampleT a, input gainT g);
		logic [15:0] product;
		product = a * g + 16'd127;
		return sampleT'(product / 16'd255);
	endfunction

	logic [8:0] weightedSum; // Extra bit catches overflow
	sampleT     mixLevel;    // Clipped sum of both voices
	logic       levelValid;

	//----------------------------------------------------------------------
	// Stage 1 gain and sum
	//----------------------------------------------------------------------
	assign weightedSum = {1'b0, scale(sineSample, sineGain)}
		+ {1'b0, scale(triangleSample, triangleGain)};

	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			levelValid <= 1'b0;
			mixValid <= 1'b0;
		end else begin
			levelValid <= toneValid;
			mixValid <= levelValid;
		end
	end

	//----------------------------------------------------------------------
	// Stage 2 volume
	//----------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (toneValid) begin
			mixLevel <= weightedSum[8] ? 8'd255 : weightedSum[7:0]; // Saturate
		end
		if (levelValid) begin
			mixCode <= {scale(mixLevel, volume), 4'b0000}; // Times 16
		end
	end

endmodule

// ==== hdl/dacSpiSerializer.sv ====
// Three-wire DAC link sending 16-bit frames MSB first
// Data changes on rising SCLK and the DAC samples it on falling SCLK
// A sample that arrives while a frame is going out is dropped
// Frame length is 2*sclkHalfPeriod*16 clocks plus 2 for open and close

module dacSpiSerializer import musicBoxPkg::*; #(
	parameter int sclkHalfPeriod = 2 // Clocks per SCLK phase
) (
	input  logic    clock_50Mhz,
	input  logic    reset,
	input  dacCodeT mixCode,
	input  logic    mixValid,
	output logic    dacSclk,
	output logic    dacSyncN, // Low for the whole frame
	output logic    dacDin
);
	localparam int halfWidth = $clog2(sclkHalfPeriod + 1);
	localparam logic [halfWidth-1:0] halfLast = halfWidth'(sclkHalfPeriod - 1);
	localparam int bitWidth = $clog2(dacFrameWidth);
	localparam logic [bitWidth-1:0] bitLast = bitWidth'(dacFrameWidth - 1);

	logic [dacFrameWidth-1:0] shiftReg; // Frame bits still to send
	logic [halfWidth-1:0]     halfCount; // Clocks into the SCLK phase
	logic [bitWidth-1:0]      fallCount; // Falling edges so far
	logic                     frameDone; // Last falling edge just passed
	logic                     sending;
	logic                     phaseEnd;  // SCLK toggles at this edge

	assign sending = ~dacSyncN;
	assign phaseEnd = sending && !frameDone && (halfCount == halfLast);

	//----------------------------------------------------------------------
	// Frame control
	//----------------------------------------------------------------------
	always_ff @(posedge clock_50Mhz) begin
		if (reset) begin
			dacSyncN <= 1'b1;
			dacSclk <= 1'b0;
			dacDin <= 1'b0;
			halfCount <= '0;
			fallCount <= '0;
			frameDone <= 1'b0;
		end else if (!sending) begin
			// Idle with SCLK low and waiting for a sample
			if (mixValid) begin
				dacSyncN <= 1'b0;
				halfCount <= '0;
				fallCount <= '0;
			end
		end else if (frameDone) begin
			dacSyncN <= 1'b1; // Close one clock after the 16th fall
			dacDin <= 1'b0;
			frameDone <= 1'b0;
		end else if (phaseEnd) begin
			halfCount <= '0;
			dacSclk <= ~dacSclk;
			if (!dacSclk) begin
				dacDin <= shiftReg[dacFrameWidth-1]; // Rising edge drives the bit
			end else begin
				fallCount <= fallCount + 1'b1; // DAC takes the bit here
				if (fallCount == bitLast) begin
					frameDone <= 1'b1;
				end
			end
		end else begin
			halfCount <= halfCount + 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Shift register
	//----------------------------------------------------------------------
	// Control nibble goes out first and then the code
	always_ff @(posedge clock_50Mhz) begin
		if (!sending && mixValid) begin
			shiftReg <= {dacControlBits, mixCode};
		end else if (phaseEnd && !dacSclk) begin
			shiftReg <= shiftReg << 1; // Next bit to the top
		end
	end

endmodule

// ==== hdl/musicBoxSynth.sv ====
// Sine and triangle tone synthesizer driving a serial DAC
// clocksPerSample must leave room for one whole DAC frame per sample
// Tone and gain inputs are synchronous to clock_50Mhz

module musicBoxSynth import musicBoxPkg::*; #(
	parameter int clocksPerSample = 1562, // About 32 kHz from 50 MHz
	parameter int sclkHalfPeriod = 2      // SCLK at 12.5 MHz
) (
	input  logic  clock_50Mhz,
	input  logic  reset,
	input  phaseT toneStep,     // Sets the tone pitch
	input  gainT  sineGain,
	input  gainT  triangleGain,
	input  gainT  volume,
	output logic  dacSclk,
	output logic  dacSyncN,
	output logic  dacDin
);
	// Frame plus open, close and a little slack must fit in one sample
	if (clocksPerSample < dacFrameWidth * 2 * sclkHalfPeriod + 4) begin : frameFitCheck
		$error("clocksPerSample too small for one DAC frame per sample");
	end

	logic    sampleTick;
	sampleT  sineSample;
	sampleT  triangleSample;
	logic    toneValid;
	dacCodeT mixCode;
	logic    mixValid;

	//----------------------------------------------------------------------
	// Tone path
	//----------------------------------------------------------------------
	sampleStrobe #(
		.clocksPerSample(clocksPerSample)
	) strobeGen (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.sampleTick(sampleTick)
	);

	toneOscillator oscillator (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.sampleTick(sampleTick),
		.toneStep(toneStep),
		.sineSample(sineSample),
		.triangleSample(triangleSample),
		.toneValid(toneValid)
	);

	amplitudeMixer mixer (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.sineSample(sineSample),
		.triangleSample(triangleSample),
		.toneValid(toneValid),
		.sineGain(sineGain),
		.triangleGain(triangleGain),
		.volume(volume),
		.mixCode(mixCode),
		.mixValid(mixValid)
	);

	dacSpiSerializer #(
		.sclkHalfPeriod(sclkHalfPeriod)
	) dacLink (
		.clock_50Mhz(clock_50Mhz),
		.reset(reset),
		.mixCode(mixCode),
		.mixValid(mixValid),
		.dacSclk(dacSclk),
		.dacSyncN(dacSyncN),
		.dacDin(dacDin)
	);

endmodule

// ==== tests/musicBoxSynthTb.sv ====
// Testbench for the tone path down to the serial DAC frames
// Expected frames come from the sine, triangle and gain rules with $sin for the wave
// Frames are captured on falling SCLK sampled at the falling system clock
// Uses a short sample period of 100 clocks so frames come quickly

module musicBoxSynthTb import musicBoxPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clocksPerSample = 100;
	localparam int sclkHalfPeriod = 2;
	localparam int frameTimeout = 2000; // Clocks allowed per frame wait
	localparam real pi = 3.14159265358979;

	logic  clock;
	logic  reset;
	phaseT toneStep;
	gainT  sineGain;
	gainT  triangleGain;
	gainT  volume;
	logic  dacSclk;
	logic  dacSyncN;
	logic  dacDin;

	logic [15:0] frameQ[$];        // Frames since the last reset
	logic [15:0] shiftData;        // Frame being assembled
	int          bitCount;         // Falling SCLK edges in this frame
	int          negEdgeCount;     // Free running clock count
	int          lastSyncFall;     // Count at the last frame start, -1 if none
	logic        prevSyncN;
	logic        prevSclk;
	logic [31:0] lfsrState;
	string       currentTest;      // Name of the test now running

	musicBoxSynth #(
		.clocksPerSample(clocksPerSample),
		.sclkHalfPeriod(sclkHalfPeriod)
	) u_dut (
		.clock_50Mhz(clock),
		.reset(reset),
		.toneStep(toneStep),
		.sineGain(sineGain),
		.triangleGain(triangleGain),
		.volume(volume),
		.dacSclk(dacSclk),
		.dacSyncN(dacSyncN),
		.dacDin(dacDin)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	//----------------------------------------------------------------------
	// Failure reporting
	//----------------------------------------------------------------------
	task automatic endInFailure();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic printMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
		$display("Fail %s expected %0h actual %0h", testName, expected, actual);
		endInFailure();
	endtask

	task automatic stopWithError(string why);
		$display("%s", why);
		endInFailure();
	endtask

	//----------------------------------------------------------------------
	// Reference model
	//----------------------------------------------------------------------
	function automatic int sineRef(int n);
		real level;
		level = 127.5 + 127.5 * $sin(2.0 * pi * (n + 0.5) / 256.0);
		return $rtoi(level + 0.5); // Always positive so this rounds
	endfunction

	function automatic int triangleRef(int n);
		return (n < 128) ? 2 * n : 2 * (255 - n);
	endfunction

	function automatic int scaleRef(int a, int g);
		return (a * g + 127) / 255; // Remainder dropped
	endfunction

	// Unclipped weighted sum for sample k
	function automatic int mixRaw(int k, phaseT step, gainT sg, gainT tg);
		int phase;
		int n;
		phase = (k * int'(step)) % 65536;
		n = phase / 256; // Top 8 phase bits
		return scaleRef(sineRef(n), sg) + scaleRef(triangleRef(n), tg);
	endfunction

	function automatic logic [15:0] expectedFrame(int k, phaseT step, gainT sg, gainT tg,
		gainT vol);
		int mix;
		int code;
		mix = mixRaw(k, step, sg, tg);
		if (mix > 255) begin
			mix = 255; // Clip
		end
		code = scaleRef(mix, vol) * 16;
		return {4'b0000, code[11:0]}; // Control nibble leads
	endfunction

	// Galois LFSR, one step per bit taken
	task automatic takeRandomBits(int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	//----------------------------------------------------------------------
	// Frame capture and format checks
	//----------------------------------------------------------------------
	always @(negedge clock) begin
		negEdgeCount++;
		if (reset) begin
			frameQ.delete();
			bitCount = 0;
			lastSyncFall = -1;
		end else begin
			assert (!(dacSyncN && dacSclk))
				else stopWithError("dacSclk was high while dacSyncN was high");
			if (prevSyncN && !dacSyncN) begin // Frame opens
				if (lastSyncFall >= 0) begin
					assert (negEdgeCount - lastSyncFall == clocksPerSample)
						else printMismatch({currentTest, " sync spacing"}, clocksPerSample,
							negEdgeCount - lastSyncFall);
				end
				lastSyncFall = negEdgeCount;
				bitCount = 0;
				shiftData = '0;
			end
			if (!dacSyncN && prevSclk && !dacSclk) begin
				shiftData = {shiftData[14:0], dacDin}; // MSB first
				bitCount++;
			end
			if (!prevSyncN && dacSyncN) begin // Frame closes
				assert (bitCount == dacFrameWidth)
					else printMismatch({currentTest, " frame length"}, dacFrameWidth,
						bitCount);
				assert (shiftData[15:12] == 4'b0000)
					else printMismatch({currentTest, " control bits"}, 0, shiftData[15:12]);
				frameQ.push_back(shiftData);
			end
		end
		prevSyncN = dacSyncN;
		prevSclk = dacSclk;
	end

	//----------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------
	task automatic applyReset(phaseT step, gainT sg, gainT tg, gainT vol);
		@(posedge clock);
		#1;
		reset = 1'b1;
		toneStep = step;
		sineGain = sg;
		triangleGain = tg;
		volume = vol;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic waitForFrames(int count);
		int waited;
		waited = 0;
		while (frameQ.size() < count) begin
			if (waited == frameTimeout) begin
				stopWithError("timed out waiting for a DAC frame");
			end
			@(posedge clock);
			#1;
			waited++;
		end
	endtask

	task automatic checkFrames(string name, phaseT step, gainT sg, gainT tg, gainT vol,
		int count);
		logic [15:0] expected;
		string       label;
		for (int k = 1; k <= count; k++) begin
			waitForFrames(k);
			expected = expectedFrame(k, step, sg, tg, vol);
			label = $sformatf("%s frame %0d", name, k);
			assert (frameQ[k-1] == expected)
				else printMismatch(label, expected, frameQ[k-1]);
			if (vol == 8'd255 && mixRaw(k, step, sg, tg) > 255) begin
				assert (frameQ[k-1] == 16'h0FF0) // Full scale after clipping
					else printMismatch({label, " clip"}, 16'h0FF0, frameQ[k-1]);
			end
		end
	endtask

	task automatic runTest(string name, phaseT step, gainT sg, gainT tg, gainT vol);
		currentTest = name;
		applyReset(step, sg, tg, vol);
		checkFrames(name, step, sg, tg, vol, 20);
	endtask

	task automatic checkResetMidFrame(string name, phaseT step, gainT sg, gainT tg,
		gainT vol);
		int waited;
		currentTest = name;
		applyReset(step, sg, tg, vol);
		checkFrames(name, step, sg, tg, vol, 2);
		waited = 0;
		while (dacSyncN !== 1'b0) begin // Next frame opening
			if (waited == frameTimeout) begin
				stopWithError("timed out waiting for a DAC frame to start");
			end
			@(posedge clock);
			#1;
			waited++;
		end
		repeat (20) @(posedge clock); // Well inside the 66-clock frame
		#1;
		reset = 1'b1;
		@(posedge clock);
		#1;
		assert (dacSyncN === 1'b1 && dacSclk === 1'b0)
			else stopWithError("reset did not stop the DAC frame within one cycle");
		repeat (9) @(posedge clock);
		#1;
		reset = 1'b0;
		checkFrames({name, " after release"}, step, sg, tg, vol, 1); // Sample k = 1 again
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		logic [31:0] bits;
		phaseT       randomStep;
		reset = 1'b1;
		toneStep = '0;
		sineGain = '0;
		triangleGain = '0;
		volume = '0;
		frameQ.delete();
		shiftData = '0;
		bitCount = 0;
		negEdgeCount = 0;
		lastSyncFall = -1;
		prevSyncN = 1'b1;
		prevSclk = 1'b0;
		currentTest = "power up";
		lfsrState = 32'h3f15;

		runTest("sine fixed step", 16'h0D00, 8'd255, 8'd0, 8'd255);
		takeRandomBits(16, bits);
		randomStep = bits[15:0];
		runTest("sine random step", randomStep, 8'd255, 8'd0, 8'd255);

		runTest("triangle fixed step", 16'h0A40, 8'd0, 8'd255, 8'd255);
		takeRandomBits(16, bits);
		randomStep = bits[15:0];
		runTest("triangle random step", randomStep, 8'd0, 8'd255, 8'd255);

		runTest("half mix", 16'h0B00, 8'd128, 8'd128, 8'd255);
		runTest("saturation", 16'h0D00, 8'd255, 8'd255, 8'd255); // Peaks clip near n = 64

		runTest("volume zero", 16'h0D00, 8'd255, 8'd255, 8'd0);
		takeRandomBits(16, bits);
		randomStep = bits[15:0];
		runTest("volume 64", randomStep, 8'd128, 8'd128, 8'd64);

		checkResetMidFrame("reset mid frame", 16'h0C80, 8'd255, 8'd0, 8'd255);

		$display("test passed");
		$finish;
	end

endmodule

// ==== musicBox.f ====
hdl/musicBoxPkg.sv
hdl/sampleStrobe.sv
hdl/toneOscillator.sv
hdl/amplitudeMixer.sv
hdl/dacSpiSerializer.sv
hdl/musicBoxSynth.sv
tests/musicBoxSynthTb.sv

// ==== Bender.yml ====
package:
  name: musicBox

sources:
  - files:
      - hdl/musicBoxPkg.sv
      - hdl/sampleStrobe.sv
      - hdl/toneOscillator.sv
      - hdl/amplitudeMixer.sv
      - hdl/dacSpiSerializer.sv
      - hdl/musicBoxSynth.sv
  - target: test
    files:
      - tests/musicBoxSynthTb.sv
